//--- files.f
verilog/mcu_pkg.sv
verilog/ram_wr_if.sv
verilog/line_ram.sv
verilog/strip_writer.sv
verilog/mcu_reader.sv
verilog/mcu_buffer.sv
tb/tb_clk_gen.sv
tb/mcu_buffer_assert.sv
tb/mcu_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mcu_buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mcu_buffer_tb \
    -f files.f -o sim_mcu_buffer
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_mcu_buffer > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ] || ! grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    echo "simulation ended abnormally"
    exit 1
fi
echo "simulation passed"
exit 0

//--- tb/mcu_buffer_assert.sv
module mcu_buffer_assert (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        row_hold_i,
    input  logic [8*mcu_pkg::DW-1:0]    row_data_i,
    input  logic                        row_valid_i,
    input  logic [2:0]                  row_idx_i
);

    // no row shows in the first cycle out of reset
    a_reset_quiet: assert property (@(posedge clk) !resetn |=> !row_valid_i)
        else $error("row_valid_o high in the cycle after reset");

    // a held row keeps its data, index and valid
    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        (row_hold_i && row_valid_i) |=>
            (row_valid_i && $stable(row_data_i) && $stable(row_idx_i)))
        else $error("row outputs changed while row_hold_i was high");

    // the next shown row is the following row of the block, wrapping at 8
    a_idx_step: assert property (@(posedge clk) disable iff (!resetn)
        (row_valid_i && !row_hold_i) |=>
            (!row_valid_i || row_idx_i == $past(row_idx_i) + 3'd1))
        else $error("row_idx_o did not step by one between rows");

endmodule

//--- tb/mcu_buffer_tb.sv
module mcu_buffer_tb;

    // model frame stride equals the widest test frame
    localparam int FW = 64;
    // beats of all frames at five beats per 2x2 cell
    localparam int TOTAL_BEATS = (32*16 + 48*32 + 32*48 + 16*16 + 64*32) * 5 / 4;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 4000;

    logic                       clk;
    logic                       resetn;
    logic [mcu_pkg::DW-1:0]     pix_y_i;
    logic [mcu_pkg::DW-1:0]     pix_u_i;
    logic [mcu_pkg::DW-1:0]     pix_v_i;
    logic [2:0]                 pix_valid_i;
    logic [mcu_pkg::XW-1:0]     pix_x_i;
    logic [mcu_pkg::YW-1:0]     pix_line_i;
    logic [mcu_pkg::XW-1:0]     x_size_m1_i;
    logic [mcu_pkg::YW-1:0]     y_size_m1_i;
    logic                       row_hold_i;
    logic                       pix_hold_o;
    logic [8*mcu_pkg::DW-1:0]   row_o;
    logic                       row_valid_o;
    logic [2:0]                 row_idx_o;

    logic [15:0]    lfsr_state;
    logic [7:0]     y_pix [FW*FW];
    logic [7:0]     u_pix [FW*FW];
    logic [7:0]     v_pix [FW*FW];
    logic [63:0]    exp_data [$];
    logic [2:0]     exp_idx [$];
    logic           exp_chroma [$];
    int             errors;
    int             chroma_errors;
    int             rows_seen;
    int             tests_passed;
    int             tests_failed;
    int             cur_w;
    int             cur_h;
    int             strips_done;
    int             hold_mode;
    int             hold_cnt;
    logic           saw_pix_hold;
    logic           hold_release;

    tb_clk_gen i_tb_clk_gen (.clk_o(clk));

    mcu_buffer i_mcu_buffer (.*);

    bind mcu_buffer mcu_buffer_assert i_mcu_buffer_assert (
        .clk         (clk),
        .resetn      (resetn),
        .row_hold_i  (row_hold_i),
        .row_data_i  (row_o),
        .row_valid_i (row_valid_o),
        .row_idx_i   (row_idx_o)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic fill_frame(input int w, input int h);
        for (int l = 0; l < h; l++) begin
            for (int x = 0; x < w; x++) begin
                y_pix[l*FW+x] = rand_bits(8);
                u_pix[l*FW+x] = rand_bits(8);
                v_pix[l*FW+x] = rand_bits(8);
            end
        end
    endtask

    // expected rows by strip, block column, y0 y1 y2 y3 u v and row
    task automatic build_expected(input int w, input int h);
        logic [63:0] word;
        int line;
        int col;
        for (int s = 0; s < h/16; s++) begin
            for (int bx = 0; bx < w/16; bx++) begin
                for (int m = 0; m < 6; m++) begin
                    for (int r = 0; r < 8; r++) begin
                        for (int j = 0; j < 8; j++) begin
                            if (m < 4) begin
                                line = s*16 + (m/2)*8 + r;
                                col = bx*16 + (m%2)*8 + j;
                                word[j*8 +: 8] = y_pix[line*FW+col] - 8'd128;
                            end else begin
                                // chroma comes from the even/even pixel of the cell
                                line = s*16 + 2*r;
                                col = bx*16 + 2*j;
                                word[j*8 +: 8] = (m == 4 ? u_pix[line*FW+col]
                                                         : v_pix[line*FW+col]) - 8'd128;
                            end
                        end
                        exp_data.push_back(word);
                        exp_idx.push_back(3'(r));
                        exp_chroma.push_back(m >= 4);
                    end
                end
            end
        end
    endtask

    // a held beat is driven again until it is taken
    task automatic send_beat(input int x, input int line, input logic [2:0] valid);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            pix_x_i     <= mcu_pkg::XW'(x);
            pix_line_i  <= mcu_pkg::YW'(line);
            pix_valid_i <= valid;
            pix_y_i     <= y_pix[line*FW+x];
            pix_u_i     <= u_pix[line*FW+x];
            pix_v_i     <= v_pix[line*FW+x];
            // hold level seen here is what the dut samples at the next edge
            @(negedge clk);
            accepted = !pix_hold_o;
        end
        // the completing luma beat of a strip
        if (valid[0] && x == cur_w-1 && (line%16 == 15 || line == cur_h-1)) begin
            strips_done++;
        end
    endtask

    task automatic run_frame(input int w, input int h);
        cur_w = w;
        cur_h = h;
        // frame data and model built away from the rising edge
        fill_frame(w, h);
        build_expected(w, h);
        @(posedge clk);
        x_size_m1_i <= mcu_pkg::XW'(w-1);
        y_size_m1_i <= mcu_pkg::YW'(h-1);
        // y+u and then v alone on even/even pixels and y alone on the others
        for (int l = 0; l < h; l++) begin
            for (int x = 0; x < w; x++) begin
                if (l%2 == 0 && x%2 == 0) begin
                    send_beat(x, l, 3'b011);
                    send_beat(x, l, 3'b100);
                end else begin
                    send_beat(x, l, 3'b001);
                end
            end
        end
        @(posedge clk);
        pix_valid_i <= 3'b000;
        hold_release = 1'b1;
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        // any row in this quiet stretch is an extra
        repeat (24) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    // row taken at the edge where it is valid and not held
    always @(negedge clk) begin
        if (resetn && row_valid_o && !row_hold_i) begin
            if (exp_data.size() == 0) begin
                $display("t=%0t a row came out when no row was due", $time);
                errors++;
            end else begin
                rows_seen++;
                if (row_o !== exp_data[0]) begin
                    $display("ERR t=%0t row_o exp=%h got=%h", $time, exp_data[0], row_o);
                    errors++;
                    if (exp_chroma[0]) begin
                        chroma_errors++;
                    end
                end
                if (row_idx_o !== exp_idx[0]) begin
                    $display("ERR t=%0t row_idx_o exp=%0d got=%0d", $time, exp_idx[0], row_idx_o);
                    errors++;
                end
                void'(exp_data.pop_front());
                void'(exp_idx.pop_front());
                void'(exp_chroma.pop_front());
            end
        end
    end

    // the long output hold is released a while after the input stalls
    always @(negedge clk) begin
        if (hold_mode == 2 && pix_hold_o && !saw_pix_hold) begin
            saw_pix_hold = 1'b1;
            if (strips_done != 2) begin
                $display("t=%0t pix_hold_o rose after %0d strips instead of 2", $time, strips_done);
                errors++;
            end
        end
        if (saw_pix_hold && !hold_release) begin
            hold_cnt++;
            if (hold_cnt >= 64) begin
                hold_release = 1'b1;
            end
        end
    end

    // downstream hold: off, random one cycle in four, or one long stretch
    always @(posedge clk) begin
        if (hold_mode == 1) begin
            row_hold_i <= (rand_bits(2) == 8'd3);
        end else if (hold_mode == 2) begin
            row_hold_i <= !hold_release;
        end else begin
            row_hold_i <= 1'b0;
        end
    end

    // watchdog sized from the beats of all frames
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d rows still due",
                 WATCHDOG_CYCLES, exp_data.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int e0;
        int c0;
        lfsr_state = 16'd8121;
        resetn = 1'b0;
        pix_y_i = '0;
        pix_u_i = '0;
        pix_v_i = '0;
        pix_valid_i = 3'b000;
        pix_x_i = '0;
        pix_line_i = '0;
        x_size_m1_i = '0;
        y_size_m1_i = '0;
        row_hold_i = 1'b0;
        errors = 0;
        chroma_errors = 0;
        rows_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        strips_done = 0;
        hold_mode = 0;
        hold_cnt = 0;
        saw_pix_hold = 1'b0;
        hold_release = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        e0 = errors;
        @(negedge clk);
        if (pix_hold_o !== 1'b0) begin
            $display("ERR t=%0t pix_hold_o exp=0 got=%b", $time, pix_hold_o);
            errors++;
        end
        repeat (20) begin
            if (row_valid_o !== 1'b0) begin
                $display("ERR t=%0t row_valid_o exp=0 got=%b", $time, row_valid_o);
                errors++;
            end
            @(negedge clk);
        end
        report_test("reset", errors - e0);

        e0 = errors;
        c0 = chroma_errors;
        run_frame(32, 16);
        report_test("luma blocks", (errors - e0) - (chroma_errors - c0));
        report_test("chroma blocks", chroma_errors - c0);

        e0 = errors;
        hold_mode = 1;
        run_frame(48, 32);
        hold_mode = 0;
        report_test("output back-pressure", errors - e0);

        e0 = errors;
        strips_done = 0;
        hold_release = 1'b0;
        hold_mode = 2;
        run_frame(32, 48);
        hold_mode = 0;
        if (!saw_pix_hold) begin
            $display("pix_hold_o never rose while the output was held");
            errors++;
        end
        report_test("input back-pressure", errors - e0);

        e0 = errors;
        run_frame(16, 16);
        run_frame(64, 32);
        report_test("size change", errors - e0);

        $display("summary: %0d tests passed, %0d failed, %0d rows checked, %0d errors",
                 tests_passed, tests_failed, rows_seen, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o
);

    // free running clock, period 8
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

endmodule

//--- verilog/line_ram.sv
module line_ram #(
    parameter int DEPTH = 2880
) (
    input  logic                            clk,
    ram_wr_if.mem                           wr,
    input  logic [$clog2(DEPTH)-1:0]        ra_i,
    input  logic                            re_i,
    output logic [8*mcu_pkg::DW-1:0]        rd_o
);

    logic [8*mcu_pkg::DW-1:0] mem [DEPTH];

    // byte-masked write, one lane per pixel within the word
    always_ff @(posedge clk) begin
        if (wr.we) begin
            for (int i = 0; i < 8; i++) begin
                if (wr.wbe[i]) begin
                    mem[wr.wa][i*mcu_pkg::DW +: mcu_pkg::DW] <= wr.wd[i*mcu_pkg::DW +: mcu_pkg::DW];
                end
            end
        end
    end

    // registered read
    // data stays put while the consumer is held, re_i is low then
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i];
        end
    end

endmodule

//--- verilog/mcu_buffer.sv
module mcu_buffer (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [mcu_pkg::DW-1:0]      pix_y_i,
    input  logic [mcu_pkg::DW-1:0]      pix_u_i,
    input  logic [mcu_pkg::DW-1:0]      pix_v_i,
    input  logic [2:0]                  pix_valid_i,
    input  logic [mcu_pkg::XW-1:0]      pix_x_i,
    input  logic [mcu_pkg::YW-1:0]      pix_line_i,
    input  logic [mcu_pkg::XW-1:0]      x_size_m1_i,
    input  logic [mcu_pkg::YW-1:0]      y_size_m1_i,
    input  logic                        row_hold_i,
    output logic                        pix_hold_o,
    output logic [8*mcu_pkg::DW-1:0]    row_o,
    output logic                        row_valid_o,
    output logic [2:0]                  row_idx_o
);

    logic [1:0]                     wptr;
    logic [1:0]                     rptr;
    logic [mcu_pkg::Y_AW-1:0]       y_ra;
    logic                           y_re;
    logic [8*mcu_pkg::DW-1:0]       y_rd;
    logic [mcu_pkg::UV_AW-1:0]      uv_ra;
    logic                           uv_re;
    logic [8*mcu_pkg::DW-1:0]       uv_rd;

    ram_wr_if #(.AW(mcu_pkg::Y_AW))  y_wr_bus ();
    ram_wr_if #(.AW(mcu_pkg::UV_AW)) uv_wr_bus ();

    // raster side owns both write ports
    strip_writer i_strip_writer (
        .clk         (clk),
        .resetn      (resetn),
        .pix_y_i     (pix_y_i),
        .pix_u_i     (pix_u_i),
        .pix_v_i     (pix_v_i),
        .pix_valid_i (pix_valid_i),
        .pix_x_i     (pix_x_i),
        .pix_line_i  (pix_line_i),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .rptr_i      (rptr),
        .pix_hold_o  (pix_hold_o),
        .wptr_o      (wptr),
        .y_wr        (y_wr_bus),
        .uv_wr       (uv_wr_bus)
    );

    line_ram #(.DEPTH(mcu_pkg::Y_DEPTH)) y_ram (
        .clk  (clk),
        .wr   (y_wr_bus),
        .ra_i (y_ra),
        .re_i (y_re),
        .rd_o (y_rd)
    );

    line_ram #(.DEPTH(mcu_pkg::UV_DEPTH)) uv_ram (
        .clk  (clk),
        .wr   (uv_wr_bus),
        .ra_i (uv_ra),
        .re_i (uv_re),
        .rd_o (uv_rd)
    );

    // block side owns both read ports
    mcu_reader i_mcu_reader (
        .clk         (clk),
        .resetn      (resetn),
        .x_size_m1_i (x_size_m1_i),
        .y_size_m1_i (y_size_m1_i),
        .wptr_i      (wptr),
        .y_rd_i      (y_rd),
        .uv_rd_i     (uv_rd),
        .row_hold_i  (row_hold_i),
        .rptr_o      (rptr),
        .y_ra_o      (y_ra),
        .y_re_o      (y_re),
        .uv_ra_o     (uv_ra),
        .uv_re_o     (uv_re),
        .row_o       (row_o),
        .row_valid_o (row_valid_o),
        .row_idx_o   (row_idx_o)
    );

endmodule

//--- verilog/mcu_pkg.sv
package mcu_pkg;

    // bits per pixel component
    localparam int DW = 8;

    // largest frame the line memories are sized for
    localparam int MAX_X = 720;
    localparam int MAX_Y = 720;

    // column and line count widths, also used for the size-minus-one ports
    localparam int XW = $clog2(MAX_X);
    localparam int YW = $clog2(MAX_Y);

    // jpeg level shift, subtracted from every sample on the way in
    localparam logic [DW-1:0] LEVEL_SHIFT = 8'd128;

    // luma store: two strips of 16 lines, eight pixels per word
    localparam int Y_DEPTH = 2 * MAX_X * 16 / 8;

    // chroma store: two strips of 8 chroma lines, half width, u and v interleaved
    localparam int UV_DEPTH = 2 * 2 * (MAX_X / 2) * 8 / 8;

    // address widths of the two line memories
    localparam int Y_AW  = $clog2(Y_DEPTH);
    localparam int UV_AW = $clog2(UV_DEPTH);

    // horizontal and vertical 16x16 block counters
    // must equal XW-4 and YW-4 so they compare against size_m1 >> 4
    localparam int BLK_W = 6;

endpackage

//--- verilog/mcu_reader.sv
module mcu_reader (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [mcu_pkg::XW-1:0]          x_size_m1_i,
    input  logic [mcu_pkg::YW-1:0]          y_size_m1_i,
    input  logic [1:0]                      wptr_i,
    input  logic [8*mcu_pkg::DW-1:0]        y_rd_i,
    input  logic [8*mcu_pkg::DW-1:0]        uv_rd_i,
    input  logic                            row_hold_i,
    output logic [1:0]                      rptr_o,
    output logic [mcu_pkg::Y_AW-1:0]        y_ra_o,
    output logic                            y_re_o,
    output logic [mcu_pkg::UV_AW-1:0]       uv_ra_o,
    output logic                            uv_re_o,
    output logic [8*mcu_pkg::DW-1:0]        row_o,
    output logic                            row_valid_o,
    output logic [2:0]                      row_idx_o
);

    logic                       empty;
    logic                       step;
    logic                       last_row;
    logic                       last_mcu;
    logic                       last_col;
    logic                       last_strip;
    logic [2:0]                 row_cnt;
    logic [2:0]                 mcu_cnt;
    logic [2:0]                 mcu_q;
    logic [mcu_pkg::BLK_W-1:0]  blk_x;
    logic [mcu_pkg::BLK_W-1:0]  blk_y;

    // nothing to read while the pointers match
    always_comb empty = (wptr_i == rptr_o);
    // one row read per unheld cycle
    always_comb step = !row_hold_i && !empty;

    always_comb last_row   = (row_cnt == 3'd7);
    always_comb last_mcu   = (mcu_cnt == 3'd5);
    always_comb last_col   = (blk_x == x_size_m1_i[mcu_pkg::XW-1:4]);
    always_comb last_strip = (blk_y == y_size_m1_i[mcu_pkg::YW-1:4]);

    // row, then y0 y1 y2 y3 u v, then block column, then strip
    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_cnt <= 3'd0;
            mcu_cnt <= 3'd0;
            blk_x   <= '0;
            blk_y   <= '0;
        end else if (step) begin
            row_cnt <= row_cnt + 3'd1;
            if (last_row) begin
                if (last_mcu) begin
                    mcu_cnt <= 3'd0;
                    if (last_col) begin
                        blk_x <= '0;
                        blk_y <= last_strip ? '0 : blk_y + 1'b1;
                    end else begin
                        blk_x <= blk_x + 1'b1;
                    end
                end else begin
                    mcu_cnt <= mcu_cnt + 3'd1;
                end
            end
        end
    end

    // strip released with the last v row of the last block column
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr_o <= 2'd0;
        end else if (step && last_row && last_mcu && last_col) begin
            rptr_o <= rptr_o + 2'd1;
        end
    end

    // luma word: block column, left/right half, top/bottom half, row, buffer
    always_comb y_ra_o = {blk_x, mcu_cnt[0], mcu_cnt[1], row_cnt, rptr_o[0]};
    // chroma word: u at count 4, v at count 5, picked by the lsb
    always_comb uv_ra_o = {blk_x, row_cnt, rptr_o[0], mcu_cnt[0]};

    always_comb y_re_o  = step && (mcu_cnt <= 3'd3);
    always_comb uv_re_o = step && (mcu_cnt > 3'd3);

    // copy of the mcu count that lines up with the ram register stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mcu_q     <= 3'd0;
            row_idx_o <= 3'd0;
        end else if (step) begin
            mcu_q     <= mcu_cnt;
            row_idx_o <= row_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            row_valid_o <= 1'b0;
        end else if (!row_hold_i) begin
            row_valid_o <= !empty;
        end
    end

    // output mux, both ram registers hold under back-pressure
    always_comb row_o = (mcu_q <= 3'd3) ? y_rd_i : uv_rd_i;

endmodule

//--- verilog/ram_wr_if.sv
interface ram_wr_if #(
    parameter int AW = 12
);

    // one write port of a line memory, eight byte lanes
    logic [AW-1:0]               wa;
    logic [8*mcu_pkg::DW-1:0]    wd;
    logic [7:0]                  wbe;
    logic                        we;

    // raster side drives the port
    modport src (output wa, output wd, output wbe, output we);

    // memory side samples it
    modport mem (input wa, input wd, input wbe, input we);

endinterface

//--- verilog/strip_writer.sv
module strip_writer (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [mcu_pkg::DW-1:0]      pix_y_i,
    input  logic [mcu_pkg::DW-1:0]      pix_u_i,
    input  logic [mcu_pkg::DW-1:0]      pix_v_i,
    input  logic [2:0]                  pix_valid_i,
    input  logic [mcu_pkg::XW-1:0]      pix_x_i,
    input  logic [mcu_pkg::YW-1:0]      pix_line_i,
    input  logic [mcu_pkg::XW-1:0]      x_size_m1_i,
    input  logic [mcu_pkg::YW-1:0]      y_size_m1_i,
    input  logic [1:0]                  rptr_i,
    output logic                        pix_hold_o,
    output logic [1:0]                  wptr_o,
    ram_wr_if.src                       y_wr,
    ram_wr_if.src                       uv_wr
);

    logic                       full;
    logic                       last_col;
    logic                       last_line;
    logic [mcu_pkg::DW-1:0]     y_shift;
    logic [mcu_pkg::DW-1:0]     c_shift;

    // both strip buffers taken when pointers differ only in the msb
    always_comb full = (wptr_o[1] != rptr_i[1]) && (wptr_o[0] == rptr_i[0]);
    always_comb pix_hold_o = full;

    always_comb last_col = (pix_x_i == x_size_m1_i);
    // line 15 of a strip, or the bottom line of the frame
    always_comb last_line = (pix_line_i[3:0] == 4'd15) || (pix_line_i == y_size_m1_i);

    // level shift, wraps modulo 256
    always_comb y_shift = pix_y_i - mcu_pkg::LEVEL_SHIFT;
    // v has priority when both chroma valids are set
    always_comb c_shift = (pix_valid_i[2] ? pix_v_i : pix_u_i) - mcu_pkg::LEVEL_SHIFT;

    // luma word address: column/8, line in strip, buffer select
    always_comb begin
        y_wr.wa  = {pix_x_i[mcu_pkg::XW-1:3], pix_line_i[3:0], wptr_o[0]};
        y_wr.wd  = {8{y_shift}};
        // on the last column the upper lanes are filled too
        y_wr.wbe = (last_col ? 8'hff : 8'h01) << pix_x_i[2:0];
        y_wr.we  = pix_valid_i[0] && !full;
    end

    // chroma word address: column/16, chroma line, buffer select, u/v select
    always_comb begin
        uv_wr.wa  = {pix_x_i[mcu_pkg::XW-1:4], pix_line_i[3:1], wptr_o[0], pix_valid_i[2]};
        uv_wr.wd  = {8{c_shift}};
        // one chroma sample per 2 columns, so lane is column/2 mod 8
        uv_wr.wbe = (last_col ? 8'hff : 8'h01) << pix_x_i[3:1];
        uv_wr.we  = (|pix_valid_i[2:1]) && !full;
    end

    // strip done on the final luma write of its last line
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr_o <= 2'd0;
        end else if (!full && pix_valid_i[0] && last_col && last_line) begin
            wptr_o <= wptr_o + 2'd1;
        end
    end

endmodule
